//--- bench/axi_lite_cdc_tb.sv
// Testbench for the AXI-Lite clock domain crossing
// Random master traffic on the source clock and random slave traffic on
// the destination clock
// Each channel is checked against a queue model

module axi_lite_cdc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ITEMS     = 200;
  localparam int MAX_CYCLE = ITEMS * 40;

  logic src_clk_i, dst_clk_i, rst_i;
  axi_lite_cdc_pkg::addr_t src_aw_addr_i, src_ar_addr_i, dst_aw_addr_o, dst_ar_addr_o;
  axi_lite_cdc_pkg::prot_t src_aw_prot_i, src_ar_prot_i, dst_aw_prot_o, dst_ar_prot_o;
  axi_lite_cdc_pkg::data_t src_w_data_i, dst_w_data_o, src_r_data_o, dst_r_data_i;
  axi_lite_cdc_pkg::strb_t src_w_strb_i, dst_w_strb_o;
  axi_lite_cdc_pkg::resp_t src_b_resp_o, dst_b_resp_i, src_r_resp_o, dst_r_resp_i;
  logic src_aw_valid_i, src_aw_ready_o, src_w_valid_i, src_w_ready_o;
  logic src_b_valid_o, src_b_ready_i, src_ar_valid_i, src_ar_ready_o;
  logic src_r_valid_o, src_r_ready_i;
  logic dst_aw_valid_o, dst_aw_ready_i, dst_w_valid_o, dst_w_ready_i;
  logic dst_b_valid_i, dst_b_ready_o, dst_ar_valid_o, dst_ar_ready_i;
  logic dst_r_valid_i, dst_r_ready_o;

  integer seed;
  logic [31:0] rnd;
  logic [31:0] rnd_d;
  int cycle;
  logic traffic_on, src_hold, dst_hold;
  logic aw_fire, w_fire, ar_fire, b_fire, r_fire;
  int aw_sent, w_sent, ar_sent, b_sent, r_sent;
  int aw_rcvd, w_rcvd, ar_rcvd, b_rcvd, r_rcvd;
  logic [63:0] aw_q[$], w_q[$], ar_q[$], b_q[$], r_q[$];

  axi_lite_cdc dut_i (.*);

  always #50 src_clk_i = ~src_clk_i;
  always #65 dst_clk_i = ~dst_clk_i;

  task automatic stop_with_error(input string msg);
    $display("ERROR: %s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // Handshakes seen at the falling edge complete at the next rising edge
  always @(negedge src_clk_i) begin
    aw_fire = !rst_i && src_aw_valid_i && src_aw_ready_o;
    w_fire  = !rst_i && src_w_valid_i && src_w_ready_o;
    ar_fire = !rst_i && src_ar_valid_i && src_ar_ready_o;
    if (aw_fire) begin
      aw_q.push_back(64'({src_aw_addr_i, src_aw_prot_i}));
      aw_sent++;
    end
    if (w_fire) begin
      w_q.push_back(64'({src_w_data_i, src_w_strb_i}));
      w_sent++;
    end
    if (ar_fire) begin
      ar_q.push_back(64'({src_ar_addr_i, src_ar_prot_i}));
      ar_sent++;
    end
    if (!rst_i && src_b_valid_o && src_b_ready_i) begin
      if (b_q.size() == 0) stop_with_error("B response arrived that was never sent");
      compare("src_b_resp_o", b_q.pop_front(), 64'(src_b_resp_o));
      b_rcvd++;
    end
    if (!rst_i && src_r_valid_o && src_r_ready_i) begin
      if (r_q.size() == 0) stop_with_error("R data arrived that was never sent");
      compare("src_r_data_o/resp", r_q.pop_front(), 64'({src_r_data_o, src_r_resp_o}));
      r_rcvd++;
    end
  end

  // Destination domain sampling
  always @(negedge dst_clk_i) begin
    b_fire = !rst_i && dst_b_valid_i && dst_b_ready_o;
    r_fire = !rst_i && dst_r_valid_i && dst_r_ready_o;
    if (b_fire) begin
      b_q.push_back(64'(dst_b_resp_i));
      b_sent++;
    end
    if (r_fire) begin
      r_q.push_back(64'({dst_r_data_i, dst_r_resp_i}));
      r_sent++;
    end
    if (!rst_i && dst_aw_valid_o && dst_aw_ready_i) begin
      if (aw_q.size() == 0) stop_with_error("AW address arrived that was never sent");
      compare("dst_aw_addr_o/prot", aw_q.pop_front(), 64'({dst_aw_addr_o, dst_aw_prot_o}));
      aw_rcvd++;
    end
    if (!rst_i && dst_w_valid_o && dst_w_ready_i) begin
      if (w_q.size() == 0) stop_with_error("W data arrived that was never sent");
      compare("dst_w_data_o/strb", w_q.pop_front(), 64'({dst_w_data_o, dst_w_strb_o}));
      w_rcvd++;
    end
    if (!rst_i && dst_ar_valid_o && dst_ar_ready_i) begin
      if (ar_q.size() == 0) stop_with_error("AR address arrived that was never sent");
      compare("dst_ar_addr_o/prot", ar_q.pop_front(), 64'({dst_ar_addr_o, dst_ar_prot_o}));
      ar_rcvd++;
    end
  end

  // Master side drive holds each item until it is taken
  always @(posedge src_clk_i) begin
    #10;
    if (rst_i || !traffic_on) begin
      src_aw_valid_i = 1'b0;
      src_w_valid_i  = 1'b0;
      src_ar_valid_i = 1'b0;
      src_b_ready_i  = 1'b0;
      src_r_ready_i  = 1'b0;
    end else begin
      if (!src_aw_valid_i || aw_fire) begin
        rnd = $random(seed);
        src_aw_valid_i = aw_sent < ITEMS && rnd[1:0] != 2'b00;
        src_aw_addr_i  = $random(seed);
        src_aw_prot_i  = rnd[4:2];
      end
      if (!src_w_valid_i || w_fire) begin
        rnd = $random(seed);
        src_w_valid_i = w_sent < ITEMS && rnd[1:0] != 2'b00;
        src_w_data_i  = $random(seed);
        src_w_strb_i  = rnd[5:2];
      end
      if (!src_ar_valid_i || ar_fire) begin
        rnd = $random(seed);
        src_ar_valid_i = ar_sent < ITEMS && rnd[1:0] != 2'b00;
        src_ar_addr_i  = $random(seed);
        src_ar_prot_i  = rnd[4:2];
      end
      rnd = $random(seed);
      src_b_ready_i = !src_hold && rnd[0];
      src_r_ready_i = !src_hold && rnd[1];
    end
  end

  // Slave side drive
  always @(posedge dst_clk_i) begin
    #10;
    if (rst_i || !traffic_on) begin
      dst_b_valid_i  = 1'b0;
      dst_r_valid_i  = 1'b0;
      dst_aw_ready_i = 1'b0;
      dst_w_ready_i  = 1'b0;
      dst_ar_ready_i = 1'b0;
    end else begin
      if (!dst_b_valid_i || b_fire) begin
        rnd_d = $random(seed);
        dst_b_valid_i = b_sent < ITEMS && rnd_d[1:0] != 2'b00;
        dst_b_resp_i  = rnd_d[3:2];
      end
      if (!dst_r_valid_i || r_fire) begin
        rnd_d = $random(seed);
        dst_r_valid_i = r_sent < ITEMS && rnd_d[1:0] != 2'b00;
        dst_r_resp_i  = rnd_d[3:2];
        dst_r_data_i  = $random(seed);
      end
      rnd_d = $random(seed);
      dst_aw_ready_i = !dst_hold && rnd_d[0];
      dst_w_ready_i  = !dst_hold && rnd_d[1];
      dst_ar_ready_i = !dst_hold && rnd_d[2];
    end
  end

  always @(posedge src_clk_i) begin
    cycle++;
    if (cycle >= MAX_CYCLE) stop_with_error("timeout, traffic did not complete in time");
  end

  initial begin
    seed = 32'h09ee0056;
    src_clk_i = 1'b0;
    dst_clk_i = 1'b0;
    rst_i = 1'b1;
    cycle = 0;
    traffic_on = 1'b0;
    src_hold = 1'b1;
    dst_hold = 1'b1;
    {aw_fire, w_fire, ar_fire, b_fire, r_fire} = '0;
    {aw_sent, w_sent, ar_sent, b_sent, r_sent} = '0;
    {aw_rcvd, w_rcvd, ar_rcvd, b_rcvd, r_rcvd} = '0;
    {src_aw_addr_i, src_aw_prot_i, src_aw_valid_i} = '0;
    {src_w_data_i, src_w_strb_i, src_w_valid_i} = '0;
    {src_ar_addr_i, src_ar_prot_i, src_ar_valid_i} = '0;
    {src_b_ready_i, src_r_ready_i} = '0;
    {dst_b_resp_i, dst_b_valid_i, dst_r_data_i, dst_r_resp_i, dst_r_valid_i} = '0;
    {dst_aw_ready_i, dst_w_ready_i, dst_ar_ready_i} = '0;
    repeat (2) @(posedge src_clk_i);
    #10 rst_i = 1'b0;

    // Idle after reset
    repeat (4) @(negedge src_clk_i);
    compare("idle valid outputs", 64'(0), 64'({src_b_valid_o, src_r_valid_o,
            dst_aw_valid_o, dst_w_valid_o, dst_ar_valid_o}));
    compare("idle ready outputs", 64'(5'h1f), 64'({src_aw_ready_o, src_w_ready_o,
            src_ar_ready_o, dst_b_ready_o, dst_r_ready_o}));

    // Every FIFO takes four items under back-pressure and then stalls
    traffic_on = 1'b1;
    repeat (40) @(negedge src_clk_i);
    compare("aw accepted under stall", 64'(4), 64'(aw_sent));
    compare("w accepted under stall", 64'(4), 64'(w_sent));
    compare("ar accepted under stall", 64'(4), 64'(ar_sent));
    compare("b accepted under stall", 64'(4), 64'(b_sent));
    compare("r accepted under stall", 64'(4), 64'(r_sent));
    compare("stalled ready outputs", 64'(0), 64'({src_aw_ready_o, src_w_ready_o,
            src_ar_ready_o, dst_b_ready_o, dst_r_ready_o}));

    // Release and run random traffic to completion
    src_hold = 1'b0;
    dst_hold = 1'b0;
    while (aw_rcvd < ITEMS || w_rcvd < ITEMS || ar_rcvd < ITEMS ||
           b_rcvd < ITEMS || r_rcvd < ITEMS) begin
      @(negedge src_clk_i);
    end
    repeat (20) @(negedge src_clk_i);

    // Every FIFO is empty again once the last item has drained
    compare("drained valid outputs", 64'(0), 64'({src_b_valid_o, src_r_valid_o,
            dst_aw_valid_o, dst_w_valid_o, dst_ar_valid_o}));
    compare("drained ready outputs", 64'(5'h1f), 64'({src_aw_ready_o, src_w_ready_o,
            src_ar_ready_o, dst_b_ready_o, dst_r_ready_o}));

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the AXI-Lite CDC simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module axi_lite_cdc_tb \
  --Mdir obj_dir -o sim_axi_lite_cdc

# The simulator exits non-zero on failure, so keep its output for the search
output="$(./obj_dir/sim_axi_lite_cdc 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
else
  exit 1
fi

//--- sources.f
+incdir+verilog
verilog/axi_lite_cdc_pkg.sv
verilog/cdc_fifo_src.sv
verilog/cdc_fifo_dst.sv
verilog/cdc_fifo_gray.sv
verilog/axi_lite_cdc.sv
bench/axi_lite_cdc_tb.sv

//--- verilog/axi_lite_cdc.sv
// AXI-Lite clock domain crossing
// One asynchronous FIFO per channel: AW, W and AR go from the src_clk_i
// domain to the dst_clk_i domain, B and R come back the other way
// Payload fields are packed into one vector per channel for the crossing

`include "axi_lite_cdc_defines.svh"

module axi_lite_cdc (
  input  logic                     src_clk_i,
  input  logic                     dst_clk_i,
  input  logic                     rst_i,
  // Source side, clocked by src_clk_i
  input  axi_lite_cdc_pkg::addr_t  src_aw_addr_i,
  input  axi_lite_cdc_pkg::prot_t  src_aw_prot_i,
  input  logic                     src_aw_valid_i,
  output logic                     src_aw_ready_o,
  input  axi_lite_cdc_pkg::data_t  src_w_data_i,
  input  axi_lite_cdc_pkg::strb_t  src_w_strb_i,
  input  logic                     src_w_valid_i,
  output logic                     src_w_ready_o,
  output axi_lite_cdc_pkg::resp_t  src_b_resp_o,
  output logic                     src_b_valid_o,
  input  logic                     src_b_ready_i,
  input  axi_lite_cdc_pkg::addr_t  src_ar_addr_i,
  input  axi_lite_cdc_pkg::prot_t  src_ar_prot_i,
  input  logic                     src_ar_valid_i,
  output logic                     src_ar_ready_o,
  output axi_lite_cdc_pkg::data_t  src_r_data_o,
  output axi_lite_cdc_pkg::resp_t  src_r_resp_o,
  output logic                     src_r_valid_o,
  input  logic                     src_r_ready_i,
  // Destination side, clocked by dst_clk_i
  output axi_lite_cdc_pkg::addr_t  dst_aw_addr_o,
  output axi_lite_cdc_pkg::prot_t  dst_aw_prot_o,
  output logic                     dst_aw_valid_o,
  input  logic                     dst_aw_ready_i,
  output axi_lite_cdc_pkg::data_t  dst_w_data_o,
  output axi_lite_cdc_pkg::strb_t  dst_w_strb_o,
  output logic                     dst_w_valid_o,
  input  logic                     dst_w_ready_i,
  input  axi_lite_cdc_pkg::resp_t  dst_b_resp_i,
  input  logic                     dst_b_valid_i,
  output logic                     dst_b_ready_o,
  output axi_lite_cdc_pkg::addr_t  dst_ar_addr_o,
  output axi_lite_cdc_pkg::prot_t  dst_ar_prot_o,
  output logic                     dst_ar_valid_o,
  input  logic                     dst_ar_ready_i,
  input  axi_lite_cdc_pkg::data_t  dst_r_data_i,
  input  axi_lite_cdc_pkg::resp_t  dst_r_resp_i,
  input  logic                     dst_r_valid_i,
  output logic                     dst_r_ready_o
);

  axi_lite_cdc_pkg::aw_chan_t aw_in, aw_out;
  axi_lite_cdc_pkg::w_chan_t  w_in,  w_out;
  axi_lite_cdc_pkg::b_chan_t  b_in,  b_out;
  axi_lite_cdc_pkg::ar_chan_t ar_in, ar_out;
  axi_lite_cdc_pkg::r_chan_t  r_in,  r_out;

  // Pack on the sending side
  assign aw_in = {src_aw_addr_i, src_aw_prot_i};
  assign w_in  = {src_w_data_i, src_w_strb_i};
  assign ar_in = {src_ar_addr_i, src_ar_prot_i};
  assign b_in  = dst_b_resp_i;
  assign r_in  = {dst_r_data_i, dst_r_resp_i};

  // Unpack on the receiving side
  assign {dst_aw_addr_o, dst_aw_prot_o} = aw_out;
  assign {dst_w_data_o, dst_w_strb_o}   = w_out;
  assign {dst_ar_addr_o, dst_ar_prot_o} = ar_out;
  assign src_b_resp_o                   = b_out;
  assign {src_r_data_o, src_r_resp_o}   = r_out;

  cdc_fifo_gray #(
    .WIDTH ( $bits(axi_lite_cdc_pkg::aw_chan_t) ), .LOG_DEPTH ( `CDC_LOG_DEPTH )
  ) i_cdc_fifo_gray_aw (
    .src_clk_i   ( src_clk_i      ), .dst_clk_i   ( dst_clk_i      ), .rst_i ( rst_i ),
    .src_data_i  ( aw_in          ), .src_valid_i ( src_aw_valid_i ),
    .src_ready_o ( src_aw_ready_o ), .dst_data_o  ( aw_out         ),
    .dst_valid_o ( dst_aw_valid_o ), .dst_ready_i ( dst_aw_ready_i )
  );

  cdc_fifo_gray #(
    .WIDTH ( $bits(axi_lite_cdc_pkg::w_chan_t) ), .LOG_DEPTH ( `CDC_LOG_DEPTH )
  ) i_cdc_fifo_gray_w (
    .src_clk_i   ( src_clk_i     ), .dst_clk_i   ( dst_clk_i     ), .rst_i ( rst_i ),
    .src_data_i  ( w_in          ), .src_valid_i ( src_w_valid_i ),
    .src_ready_o ( src_w_ready_o ), .dst_data_o  ( w_out         ),
    .dst_valid_o ( dst_w_valid_o ), .dst_ready_i ( dst_w_ready_i )
  );

  // Response goes back, so the clock roles swap
  cdc_fifo_gray #(
    .WIDTH ( $bits(axi_lite_cdc_pkg::b_chan_t) ), .LOG_DEPTH ( `CDC_LOG_DEPTH )
  ) i_cdc_fifo_gray_b (
    .src_clk_i   ( dst_clk_i     ), .dst_clk_i   ( src_clk_i     ), .rst_i ( rst_i ),
    .src_data_i  ( b_in          ), .src_valid_i ( dst_b_valid_i ),
    .src_ready_o ( dst_b_ready_o ), .dst_data_o  ( b_out         ),
    .dst_valid_o ( src_b_valid_o ), .dst_ready_i ( src_b_ready_i )
  );

  cdc_fifo_gray #(
    .WIDTH ( $bits(axi_lite_cdc_pkg::ar_chan_t) ), .LOG_DEPTH ( `CDC_LOG_DEPTH )
  ) i_cdc_fifo_gray_ar (
    .src_clk_i   ( src_clk_i      ), .dst_clk_i   ( dst_clk_i      ), .rst_i ( rst_i ),
    .src_data_i  ( ar_in          ), .src_valid_i ( src_ar_valid_i ),
    .src_ready_o ( src_ar_ready_o ), .dst_data_o  ( ar_out         ),
    .dst_valid_o ( dst_ar_valid_o ), .dst_ready_i ( dst_ar_ready_i )
  );

  // Read data also crosses back to the source domain
  cdc_fifo_gray #(
    .WIDTH ( $bits(axi_lite_cdc_pkg::r_chan_t) ), .LOG_DEPTH ( `CDC_LOG_DEPTH )
  ) i_cdc_fifo_gray_r (
    .src_clk_i   ( dst_clk_i     ), .dst_clk_i   ( src_clk_i     ), .rst_i ( rst_i ),
    .src_data_i  ( r_in          ), .src_valid_i ( dst_r_valid_i ),
    .src_ready_o ( dst_r_ready_o ), .dst_data_o  ( r_out         ),
    .dst_valid_o ( src_r_valid_o ), .dst_ready_i ( src_r_ready_i )
  );

endmodule

//--- verilog/axi_lite_cdc_defines.svh
// AXI-Lite clock domain crossing
// Global widths and FIFO depth shared by the package and the top level
// FIFO depth is given as a base-two log, 2 gives four entries per channel

`ifndef AXI_LITE_CDC_DEFINES_SVH
`define AXI_LITE_CDC_DEFINES_SVH

// Address and data width of the AXI-Lite bus
`define AXI_LITE_ADDR_WIDTH 32
`define AXI_LITE_DATA_WIDTH 32

// Log2 of the number of entries in each crossing FIFO
`define CDC_LOG_DEPTH 2

`endif

//--- verilog/axi_lite_cdc_pkg.sv
// AXI-Lite clock domain crossing package
// Channel payload vectors for AW, W, B, AR and R and the
// binary/gray pointer conversions used by both FIFO halves

`include "axi_lite_cdc_defines.svh"

package axi_lite_cdc_pkg;

  // Basic AXI-Lite fields
  typedef logic [`AXI_LITE_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXI_LITE_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_LITE_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [2:0]                        prot_t;
  typedef logic [1:0]                        resp_t;

  // Channel payloads, packed as plain vectors
  typedef logic [$bits(addr_t)+$bits(prot_t)-1:0] aw_chan_t;
  typedef logic [$bits(addr_t)+$bits(prot_t)-1:0] ar_chan_t;
  typedef logic [$bits(data_t)+$bits(strb_t)-1:0] w_chan_t;
  typedef logic [$bits(resp_t)-1:0]               b_chan_t;
  typedef logic [$bits(data_t)+$bits(resp_t)-1:0] r_chan_t;

  // Working width for pointer conversions, callers zero-extend and truncate
  typedef logic [31:0] ptr_word_t;

  // Adjacent codes differ in exactly one bit
  function automatic ptr_word_t bin_to_gray(input ptr_word_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Prefix XOR from the MSB down
  function automatic ptr_word_t gray_to_bin(input ptr_word_t gray);
    ptr_word_t bin;
    bin = gray;
    for (int i = $bits(ptr_word_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- verilog/cdc_fifo_dst.sv
// Pop half of a gray-pointer asynchronous FIFO
// Brings the remote write pointer in through a two-flop synchronizer,
// flags valid while entries are pending and selects the entry at the
// read pointer from the storage of the push half

module cdc_fifo_dst #(
  parameter int unsigned WIDTH     = 8,
  parameter int unsigned LOG_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  output logic [WIDTH-1:0]              data_o,
  output logic                          valid_o,
  input  logic                          ready_i,
  input  logic [(2**LOG_DEPTH)*WIDTH-1:0] mem_i,
  input  logic [LOG_DEPTH:0]            wptr_gray_i,
  output logic [LOG_DEPTH:0]            rptr_gray_o
);

  localparam int unsigned DEPTH = 2**LOG_DEPTH;
  localparam int unsigned PW    = LOG_DEPTH + 1;

  logic [WIDTH-1:0] mem_rd [DEPTH];
  logic [PW-1:0]    rptr_bin_q;
  logic [PW-1:0]    rptr_bin_d;
  logic [PW-1:0]    rptr_gray_q;
  logic [PW-1:0]    wptr_sync_q1;
  logic [PW-1:0]    wptr_sync_q2;
  logic             pop;

  // Two-flop synchronizer for the write pointer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_sync_q1 <= '0;
      wptr_sync_q2 <= '0;
    end else begin
      wptr_sync_q1 <= wptr_gray_i;
      wptr_sync_q2 <= wptr_sync_q1;
    end
  end

  // Gray codes are equal exactly when the binary pointers are
  assign valid_o = rptr_gray_q != wptr_sync_q2;

  assign pop        = valid_o & ready_i;
  assign rptr_bin_d = rptr_bin_q + PW'(1);

  // Read pointer, gray copy goes back to the push half
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (pop) begin
      rptr_bin_q  <= rptr_bin_d;
      rptr_gray_q <= PW'(axi_lite_cdc_pkg::bin_to_gray(
                       axi_lite_cdc_pkg::ptr_word_t'(rptr_bin_d)));
    end
  end

  for (genvar i = 0; i < DEPTH; i++) begin : g_unflatten
    assign mem_rd[i] = mem_i[i*WIDTH +: WIDTH];
  end

  // Read mux, entry was written before the pointer that exposes it
  assign data_o = mem_rd[rptr_bin_q[LOG_DEPTH-1:0]];

  assign rptr_gray_o = rptr_gray_q;

endmodule

//--- verilog/cdc_fifo_gray.sv
// Asynchronous FIFO with gray-coded pointers
// Push side runs on src_clk_i, pop side on dst_clk_i, and the two
// halves exchange only the storage contents and the gray pointers

module cdc_fifo_gray #(
  parameter int unsigned WIDTH     = 8,
  parameter int unsigned LOG_DEPTH = 2
) (
  input  logic             src_clk_i,
  input  logic             dst_clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] src_data_i,
  input  logic             src_valid_i,
  output logic             src_ready_o,
  output logic [WIDTH-1:0] dst_data_o,
  output logic             dst_valid_o,
  input  logic             dst_ready_i
);

  logic [(2**LOG_DEPTH)*WIDTH-1:0] mem;
  logic [LOG_DEPTH:0]              wptr_gray;
  logic [LOG_DEPTH:0]              rptr_gray;

  cdc_fifo_src #(
    .WIDTH       ( WIDTH       ),
    .LOG_DEPTH   ( LOG_DEPTH   )
  ) i_src (
    .clk_i       ( src_clk_i   ),
    .rst_i       ( rst_i       ),
    .data_i      ( src_data_i  ),
    .valid_i     ( src_valid_i ),
    .ready_o     ( src_ready_o ),
    .mem_o       ( mem         ),
    .wptr_gray_o ( wptr_gray   ),
    .rptr_gray_i ( rptr_gray   )
  );

  cdc_fifo_dst #(
    .WIDTH       ( WIDTH       ),
    .LOG_DEPTH   ( LOG_DEPTH   )
  ) i_dst (
    .clk_i       ( dst_clk_i   ),
    .rst_i       ( rst_i       ),
    .data_o      ( dst_data_o  ),
    .valid_o     ( dst_valid_o ),
    .ready_i     ( dst_ready_i ),
    .mem_i       ( mem         ),
    .wptr_gray_i ( wptr_gray   ),
    .rptr_gray_o ( rptr_gray   )
  );

endmodule

//--- verilog/cdc_fifo_src.sv
// Push half of a gray-pointer asynchronous FIFO
// Holds the storage array and the write pointer, publishes the write
// pointer in gray code and brings the remote read pointer in through
// a two-flop synchronizer to detect a full FIFO

module cdc_fifo_src #(
  parameter int unsigned WIDTH     = 8,
  parameter int unsigned LOG_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [WIDTH-1:0]              data_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic [(2**LOG_DEPTH)*WIDTH-1:0] mem_o,
  output logic [LOG_DEPTH:0]            wptr_gray_o,
  input  logic [LOG_DEPTH:0]            rptr_gray_i
);

  localparam int unsigned DEPTH = 2**LOG_DEPTH;
  localparam int unsigned PW    = LOG_DEPTH + 1;

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PW-1:0]    wptr_bin_q;
  logic [PW-1:0]    wptr_bin_d;
  logic [PW-1:0]    wptr_gray_q;
  logic [PW-1:0]    rptr_sync_q1;
  logic [PW-1:0]    rptr_sync_q2;
  logic [PW-1:0]    rptr_bin;
  logic             push;

  // Remote read pointer back in binary
  assign rptr_bin = PW'(axi_lite_cdc_pkg::gray_to_bin(
                      axi_lite_cdc_pkg::ptr_word_t'(rptr_sync_q2)));

  // Full when the wrap bits differ and the index bits match
  assign ready_o = (wptr_bin_q ^ rptr_bin) != {1'b1, {LOG_DEPTH{1'b0}}};

  assign push       = valid_i & ready_o;
  assign wptr_bin_d = wptr_bin_q + PW'(1);

  // Storage, read by the pop half through mem_o
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_bin_q[LOG_DEPTH-1:0]] <= data_i;
    end
  end

  // Write pointer, gray copy is registered before it crosses
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= PW'(axi_lite_cdc_pkg::bin_to_gray(
                       axi_lite_cdc_pkg::ptr_word_t'(wptr_bin_d)));
    end
  end

  // Two-flop synchronizer for the read pointer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rptr_sync_q1 <= '0;
      rptr_sync_q2 <= '0;
    end else begin
      rptr_sync_q1 <= rptr_gray_i;
      rptr_sync_q2 <= rptr_sync_q1;
    end
  end

  for (genvar i = 0; i < DEPTH; i++) begin : g_flatten
    assign mem_o[i*WIDTH +: WIDTH] = mem_q[i];
  end

  assign wptr_gray_o = wptr_gray_q;

endmodule
